//--- hdl/inout_ports.sv
`timescale 1ns/10ps

module inout_ports (
    input  logic                                    clk,
    input  logic                                    reset,
    input  noc_port_pkg::ivc_status_t               ivc_status [noc_port_pkg::num_pv],
    input  noc_port_pkg::ivc_grant_t                ivc_grant [noc_port_pkg::num_pv],
    input  noc_port_pkg::vc_onehot_t                candidate_ovc [noc_port_pkg::num_pv],
    input  logic [noc_port_pkg::num_pv-1:0]         ovc_allocated,
    input  logic [noc_port_pkg::num_pv-1:0]         credit_in,
    output logic [noc_port_pkg::num_pv-1:0]         credit_out,
    output logic [noc_port_pkg::num_pv-1:0]         ovc_is_assigned,
    output noc_port_pkg::vc_onehot_t                assigned_ovc [noc_port_pkg::num_pv],
    output logic [noc_port_pkg::num_pv-1:0]         assigned_ovc_not_full,
    output logic [noc_port_pkg::num_pv-1:0]         ovc_available,
    output noc_port_pkg::vc_onehot_t                masked_ovc_request [noc_port_pkg::num_pv]
);

    logic [noc_port_pkg::num_pv-1:0] ivc_tail;
    logic [noc_port_pkg::num_pv-1:0] ivc_release;
    noc_port_pkg::dst_onehot_t       ivc_dst [noc_port_pkg::num_pv];

    // split the input side fields
    always_comb begin
        for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
            ivc_tail[i] = ivc_status[i].tail;
            ivc_dst[i]  = ivc_status[i].dst;
        end
    end

    ivc_state u_ivc_state (
        .clk             (clk),
        .reset           (reset),
        .ivc_grant       (ivc_grant),
        .ivc_tail        (ivc_tail),
        .ovc_is_assigned (ovc_is_assigned),
        .assigned_ovc    (assigned_ovc),
        .ivc_release     (ivc_release),
        .credit_out      (credit_out)
    );

    ovc_status u_ovc_status (
        .clk                   (clk),
        .reset                 (reset),
        .ivc_grant             (ivc_grant),
        .ivc_dst               (ivc_dst),
        .assigned_ovc          (assigned_ovc),
        .ivc_release           (ivc_release),
        .ovc_allocated         (ovc_allocated),
        .credit_in             (credit_in),
        .ovc_available         (ovc_available),
        .assigned_ovc_not_full (assigned_ovc_not_full)
    );

    // requests for the VC allocator
    vc_request_mask u_vc_request_mask (
        .ivc_status         (ivc_status),
        .ovc_is_assigned    (ovc_is_assigned),
        .candidate_ovc      (candidate_ovc),
        .ovc_available      (ovc_available),
        .masked_ovc_request (masked_ovc_request)
    );

endmodule

//--- hdl/ivc_state.sv
`timescale 1ns/10ps

module ivc_state (
    input  logic                                    clk,
    input  logic                                    reset,
    input  noc_port_pkg::ivc_grant_t                ivc_grant [noc_port_pkg::num_pv],
    input  logic [noc_port_pkg::num_pv-1:0]         ivc_tail,
    output logic [noc_port_pkg::num_pv-1:0]         ovc_is_assigned,
    output noc_port_pkg::vc_onehot_t                assigned_ovc [noc_port_pkg::num_pv],
    output logic [noc_port_pkg::num_pv-1:0]         ivc_release,
    output logic [noc_port_pkg::num_pv-1:0]         credit_out
);

    logic [noc_port_pkg::num_pv-1:0] sw_grant;
    logic [noc_port_pkg::num_pv-1:0] ovc_grant;

    // pull the strobes out of the grant structs
    always_comb begin
        for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
            sw_grant[i]  = ivc_grant[i].sw_grant;
            ovc_grant[i] = ivc_grant[i].ovc_grant;
        end
    end

    // tail leaving the IVC ends the packet
    assign ivc_release = sw_grant & ivc_tail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovc_is_assigned <= '0;
            credit_out      <= '0;
            for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
                assigned_ovc[i] <= '0;
            end
        end else begin
            // one credit upstream per flit that left
            credit_out <= sw_grant;
            for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
                // release has priority over a new grant
                if (ivc_release[i]) begin
                    ovc_is_assigned[i] <= 1'b0;
                end else if (ovc_grant[i]) begin
                    ovc_is_assigned[i] <= 1'b1;
                end
                if (ovc_grant[i]) begin
                    assigned_ovc[i] <= ivc_grant[i].granted_ovc;
                end
            end
        end
    end

endmodule

//--- hdl/noc_port_pkg.sv
package noc_port_pkg;

    // router geometry
    localparam int num_ports = 5;
    localparam int num_vcs   = 4;
    localparam int num_pv    = num_ports * num_vcs;

    // an IVC never routes back to its own port
    localparam int num_dst   = num_ports - 1;

    // downstream buffer slots per output VC
    localparam int buf_depth = 4;
    localparam int credit_w  = 3;

    // one-hot VC number inside a port
    typedef logic [num_vcs-1:0] vc_onehot_t;

    // one-hot destination among the other ports
    // bit j is port j below the own port, port j+1 from the own port upwards
    typedef logic [num_dst-1:0] dst_onehot_t;

    // input side view of one IVC
    typedef struct packed {
        logic        request;
        logic        tail;
        dst_onehot_t dst;
    } ivc_status_t;

    // allocator results for one IVC
    typedef struct packed {
        logic       ovc_grant;
        vc_onehot_t granted_ovc;
        logic       sw_grant;
    } ivc_grant_t;

    // allocation state of an output VC
    typedef enum logic {
        ovc_free = 1'b0,
        ovc_busy = 1'b1
    } ovc_state_t;

endpackage

//--- hdl/ovc_status.sv
`timescale 1ns/10ps

module ovc_status (
    input  logic                                    clk,
    input  logic                                    reset,
    input  noc_port_pkg::ivc_grant_t                ivc_grant [noc_port_pkg::num_pv],
    input  noc_port_pkg::dst_onehot_t               ivc_dst [noc_port_pkg::num_pv],
    input  noc_port_pkg::vc_onehot_t                assigned_ovc [noc_port_pkg::num_pv],
    input  logic [noc_port_pkg::num_pv-1:0]         ivc_release,
    input  logic [noc_port_pkg::num_pv-1:0]         ovc_allocated,
    input  logic [noc_port_pkg::num_pv-1:0]         credit_in,
    output logic [noc_port_pkg::num_pv-1:0]         ovc_available,
    output logic [noc_port_pkg::num_pv-1:0]         assigned_ovc_not_full
);

    logic [noc_port_pkg::num_ports-1:0] dst_port [noc_port_pkg::num_pv];
    logic [noc_port_pkg::num_pv-1:0]    ovc_sent;
    logic [noc_port_pkg::num_pv-1:0]    ovc_released;
    logic [noc_port_pkg::num_pv-1:0]    ovc_not_full;
    logic [noc_port_pkg::credit_w-1:0]  credit [noc_port_pkg::num_pv];
    noc_port_pkg::ovc_state_t           ovc_state [noc_port_pkg::num_pv];
    noc_port_pkg::vc_onehot_t           dst_not_full [noc_port_pkg::num_pv];

    // expand the 4-way destination into a 5-port vector
    function automatic logic [noc_port_pkg::num_ports-1:0] decode_dst(
        input int                        own_port,
        input noc_port_pkg::dst_onehot_t dst
    );
        logic [noc_port_pkg::num_ports-1:0] port_sel;
        port_sel = '0;
        for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
            if (j < own_port) begin
                port_sel[j] = dst[j];
            end else begin
                port_sel[j + 1] = dst[j];
            end
        end
        return port_sel;
    endfunction

    // gather sends and releases per output VC
    always_comb begin
        ovc_sent     = '0;
        ovc_released = '0;
        for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
            dst_port[i] = decode_dst(i / noc_port_pkg::num_vcs, ivc_dst[i]);
            for (int q = 0; q < noc_port_pkg::num_ports; q++) begin
                for (int v = 0; v < noc_port_pkg::num_vcs; v++) begin
                    if (dst_port[i][q] && assigned_ovc[i][v]) begin
                        ovc_sent[q*noc_port_pkg::num_vcs + v] |= ivc_grant[i].sw_grant;
                        ovc_released[q*noc_port_pkg::num_vcs + v] |= ivc_release[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int o = 0; o < noc_port_pkg::num_pv; o++) begin
                credit[o]    <= noc_port_pkg::credit_w'(noc_port_pkg::buf_depth);
                ovc_state[o] <= noc_port_pkg::ovc_free;
            end
        end else begin
            for (int o = 0; o < noc_port_pkg::num_pv; o++) begin
                // saturate at both ends
                if (ovc_sent[o] && !credit_in[o] && credit[o] != '0) begin
                    credit[o] <= credit[o] - 1'b1;
                end else if (!ovc_sent[o] && credit_in[o] &&
                             credit[o] != noc_port_pkg::credit_w'(noc_port_pkg::buf_depth)) begin
                    credit[o] <= credit[o] + 1'b1;
                end
                if (ovc_released[o]) begin
                    ovc_state[o] <= noc_port_pkg::ovc_free;
                end else if (ovc_allocated[o]) begin
                    ovc_state[o] <= noc_port_pkg::ovc_busy;
                end
            end
        end
    end

    always_comb begin
        for (int o = 0; o < noc_port_pkg::num_pv; o++) begin
            ovc_not_full[o]  = (credit[o] != '0);
            ovc_available[o] = (ovc_state[o] == noc_port_pkg::ovc_free) && ovc_not_full[o];
        end
        // credit left on the OVC each IVC holds
        for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
            dst_not_full[i] = '0;
            for (int q = 0; q < noc_port_pkg::num_ports; q++) begin
                if (dst_port[i][q]) begin
                    dst_not_full[i] |= ovc_not_full[q*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs];
                end
            end
            assigned_ovc_not_full[i] = |(dst_not_full[i] & assigned_ovc[i]);
        end
    end

endmodule

//--- hdl/vc_request_mask.sv
`timescale 1ns/10ps

module vc_request_mask (
    input  noc_port_pkg::ivc_status_t               ivc_status [noc_port_pkg::num_pv],
    input  logic [noc_port_pkg::num_pv-1:0]         ovc_is_assigned,
    input  noc_port_pkg::vc_onehot_t                candidate_ovc [noc_port_pkg::num_pv],
    input  logic [noc_port_pkg::num_pv-1:0]         ovc_available,
    output noc_port_pkg::vc_onehot_t                masked_ovc_request [noc_port_pkg::num_pv]
);

    logic [noc_port_pkg::num_dst*noc_port_pkg::num_vcs-1:0] avail_perport
        [noc_port_pkg::num_ports];
    logic [noc_port_pkg::num_pv-1:0] needs_ovc;
    noc_port_pkg::vc_onehot_t        avail_muxed [noc_port_pkg::num_pv];

    // availability as seen from each input port, own port squeezed out
    always_comb begin
        for (int p = 0; p < noc_port_pkg::num_ports; p++) begin
            for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
                if (j < p) begin
                    avail_perport[p][j*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs] =
                        ovc_available[j*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs];
                end else begin
                    avail_perport[p][j*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs] =
                        ovc_available[(j + 1)*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < noc_port_pkg::num_pv; i++) begin
            // only a waiting packet without an OVC may ask
            needs_ovc[i] = ivc_status[i].request & ~ovc_is_assigned[i];

            // one-hot mux on the destination
            avail_muxed[i] = '0;
            for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
                if (ivc_status[i].dst[j]) begin
                    avail_muxed[i] |= avail_perport[i / noc_port_pkg::num_vcs]
                                      [j*noc_port_pkg::num_vcs +: noc_port_pkg::num_vcs];
                end
            end

            if (needs_ovc[i]) begin
                masked_ovc_request[i] = candidate_ovc[i] & avail_muxed[i];
            end else begin
                masked_ovc_request[i] = '0;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
verilator --binary --assert -Wno-fatal --top-module tb_inout_ports -f tb.f -o tb_sim \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "^Done: no errors$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/tb_inout_ports.sv
`timescale 1ns/10ps

module tb_inout_ports;

    localparam int clk_period    = 100;
    localparam int np            = noc_port_pkg::num_pv;
    localparam int nv            = noc_port_pkg::num_vcs;
    localparam int reset_cycles  = 10;
    // reset, then tests 1 to 6 in order
    localparam int run_cycles    = reset_cycles + 4 + 36 + 26 + 22 + 8 + 66;
    localparam int margin_cycles = 100;

    logic                     clk;
    logic                     reset;
    noc_port_pkg::ivc_status_t ivc_status [np];
    noc_port_pkg::ivc_grant_t  ivc_grant [np];
    noc_port_pkg::vc_onehot_t  candidate_ovc [np];
    logic [np-1:0]            ovc_allocated;
    logic [np-1:0]            credit_in;
    logic [np-1:0]            credit_out;
    logic [np-1:0]            ovc_is_assigned;
    noc_port_pkg::vc_onehot_t  assigned_ovc [np];
    logic [np-1:0]            assigned_ovc_not_full;
    logic [np-1:0]            ovc_available;
    noc_port_pkg::vc_onehot_t  masked_ovc_request [np];

    // reference model state
    logic [np-1:0]            m_assigned;
    noc_port_pkg::vc_onehot_t  m_ovc [np];
    logic [np-1:0]            m_credit_out;
    logic [np-1:0]            m_busy;
    int                       m_credit [np];

    logic reset_check;
    int   error_count;
    int   errors_before;
    int   tests_done;
    int   seed;

    inout_ports u_inout_ports (
        .clk                   (clk),
        .reset                 (reset),
        .ivc_status            (ivc_status),
        .ivc_grant             (ivc_grant),
        .candidate_ovc         (candidate_ovc),
        .ovc_allocated         (ovc_allocated),
        .credit_in             (credit_in),
        .credit_out            (credit_out),
        .ovc_is_assigned       (ovc_is_assigned),
        .assigned_ovc          (assigned_ovc),
        .assigned_ovc_not_full (assigned_ovc_not_full),
        .ovc_available         (ovc_available),
        .masked_ovc_request    (masked_ovc_request)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // destination index j skips the IVC's own port
    function automatic int port_of(input int ivc, input int j);
        if (j < ivc / nv) begin
            return j;
        end
        return j + 1;
    endfunction

    function automatic logic [np-1:0] predicted_available();
        logic [np-1:0] avail;
        for (int o = 0; o < np; o++) begin
            avail[o] = !m_busy[o] && (m_credit[o] > 0);
        end
        return avail;
    endfunction

    function automatic logic [np-1:0] predicted_not_full();
        logic [np-1:0] nf;
        nf = '0;
        for (int i = 0; i < np; i++) begin
            for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
                for (int v = 0; v < nv; v++) begin
                    if (ivc_status[i].dst[j] && m_ovc[i][v] &&
                        m_credit[port_of(i, j) * nv + v] > 0) begin
                        nf[i] = 1'b1;
                    end
                end
            end
        end
        return nf;
    endfunction

    function automatic logic mask_matches();
        logic [np-1:0]           avail;
        noc_port_pkg::vc_onehot_t want;
        avail = predicted_available();
        for (int i = 0; i < np; i++) begin
            want = '0;
            if (ivc_status[i].request && !m_assigned[i]) begin
                for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
                    if (ivc_status[i].dst[j]) begin
                        want |= candidate_ovc[i] & avail[port_of(i, j) * nv +: nv];
                    end
                end
            end
            if (masked_ovc_request[i] !== want) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic logic ovc_numbers_match();
        for (int i = 0; i < np; i++) begin
            if (assigned_ovc[i] !== m_ovc[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // model of the assignment, credit and allocation rules
    always @(posedge clk or posedge reset) begin
        logic [np-1:0] sent;
        logic [np-1:0] freed;
        int            o;
        if (reset) begin
            m_assigned   <= '0;
            m_credit_out <= '0;
            m_busy       <= '0;
            for (int i = 0; i < np; i++) begin
                m_ovc[i]    <= '0;
                m_credit[i] <= noc_port_pkg::buf_depth;
            end
        end else begin
            sent  = '0;
            freed = '0;
            for (int i = 0; i < np; i++) begin
                for (int j = 0; j < noc_port_pkg::num_dst; j++) begin
                    for (int v = 0; v < nv; v++) begin
                        if (ivc_status[i].dst[j] && m_ovc[i][v]) begin
                            o = port_of(i, j) * nv + v;
                            sent[o]  |= ivc_grant[i].sw_grant;
                            freed[o] |= ivc_grant[i].sw_grant & ivc_status[i].tail;
                        end
                    end
                end
                m_credit_out[i] <= ivc_grant[i].sw_grant;
                if (ivc_grant[i].sw_grant && ivc_status[i].tail) begin
                    m_assigned[i] <= 1'b0;
                end else if (ivc_grant[i].ovc_grant) begin
                    m_assigned[i] <= 1'b1;
                end
                if (ivc_grant[i].ovc_grant) begin
                    m_ovc[i] <= ivc_grant[i].granted_ovc;
                end
            end
            for (int k = 0; k < np; k++) begin
                if (sent[k] && !credit_in[k] && m_credit[k] > 0) begin
                    m_credit[k] <= m_credit[k] - 1;
                end else if (!sent[k] && credit_in[k] &&
                             m_credit[k] < noc_port_pkg::buf_depth) begin
                    m_credit[k] <= m_credit[k] + 1;
                end
                if (freed[k]) begin
                    m_busy[k] <= 1'b0;
                end else if (ovc_allocated[k]) begin
                    m_busy[k] <= 1'b1;
                end
            end
        end
    end

    // outputs are compared mid cycle, away from the driving edge
    reset_state: assert property (@(negedge clk) disable iff (reset)
        reset_check |-> (credit_out == '0 && ovc_is_assigned == '0 && (&ovc_available)
                         && assigned_ovc_not_full == '0))
        else report_error("outputs after reset are not in their reset state");
    credit_return: assert property (@(negedge clk) disable iff (reset)
        credit_out == m_credit_out)
        else report_error("credit_out differs from the model");
    assigned_flag: assert property (@(negedge clk) disable iff (reset)
        ovc_is_assigned == m_assigned)
        else report_error("ovc_is_assigned differs from the model");
    assigned_number: assert property (@(negedge clk) disable iff (reset)
        ovc_numbers_match())
        else report_error("assigned_ovc differs from the model");
    availability: assert property (@(negedge clk) disable iff (reset)
        ovc_available == predicted_available())
        else report_error("ovc_available differs from the model");
    not_full: assert property (@(negedge clk) disable iff (reset)
        assigned_ovc_not_full == predicted_not_full())
        else report_error("assigned_ovc_not_full differs from the model");
    request_mask: assert property (@(negedge clk) disable iff (reset)
        mask_matches())
        else report_error("masked_ovc_request differs from the model");

    task automatic idle_inputs();
        for (int i = 0; i < np; i++) begin
            ivc_grant[i]             <= '0;
            candidate_ovc[i]         <= '0;
            ivc_status[i].request    <= 1'b0;
            ivc_status[i].tail       <= 1'b0;
        end
        ovc_allocated <= '0;
        credit_in     <= '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        idle_inputs();
    endtask

    task automatic finish_test(input string name);
        next_cycle();
        @(negedge clk);
        #1;
        tests_done++;
        $display("test %0d (%s) finished with %0d errors", tests_done, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    // grant an OVC, send a body flit and then the tail
    task automatic assign_and_release(input int i, input int j, input int v);
        int o;
        o = port_of(i, j) * nv + v;
        next_cycle();
        ivc_status[i].dst     <= noc_port_pkg::dst_onehot_t'(1 << j);
        ivc_status[i].request <= 1'b1;
        next_cycle();
        ivc_grant[i].ovc_grant   <= 1'b1;
        ivc_grant[i].granted_ovc <= noc_port_pkg::vc_onehot_t'(1 << v);
        ovc_allocated[o]         <= 1'b1;
        next_cycle();
        ivc_grant[i].sw_grant <= 1'b1;
        next_cycle();
        credit_in[o] <= 1'b1;
        next_cycle();
        ivc_grant[i].sw_grant <= 1'b1;
        ivc_status[i].tail    <= 1'b1;
        next_cycle();
        credit_in[o] <= 1'b1;
    endtask

    initial begin
        logic [31:0] rnd;
        int          idx;
        seed          = 75952;
        error_count   = 0;
        errors_before = 0;
        tests_done    = 0;
        reset         = 1'b1;
        reset_check   = 1'b0;
        ovc_allocated = '0;
        credit_in     = '0;
        for (int i = 0; i < np; i++) begin
            ivc_status[i]    = '0;
            ivc_grant[i]     = '0;
            candidate_ovc[i] = '0;
        end

        repeat (reset_cycles) @(posedge clk);
        reset       <= 1'b0;
        reset_check <= 1'b1;
        next_cycle();
        reset_check <= 1'b0;
        finish_test("reset state");

        for (int k = 0; k < 5; k++) begin
            assign_and_release(k * nv + (k % nv), (k + 1) % 4, (k + 2) % 4);
        end
        finish_test("assignment and release");

        for (int c = 0; c < 16; c++) begin
            next_cycle();
            rnd = $random(seed);
            for (int i = 0; i < np; i++) begin
                ivc_grant[i].sw_grant <= rnd[i];
            end
            rnd = $random(seed);
            credit_in <= rnd[np-1:0];
        end
        // refill every OVC
        for (int c = 0; c < 4; c++) begin
            next_cycle();
            credit_in <= '1;
        end
        finish_test("credit return");

        // IVC 1 on port 0, destination index 0 is port 1, VC 0 is OVC 4
        next_cycle();
        ivc_status[1].dst        <= 4'b0001;
        ivc_grant[1].ovc_grant   <= 1'b1;
        ivc_grant[1].granted_ovc <= 4'b0001;
        for (int c = 0; c < noc_port_pkg::buf_depth; c++) begin
            next_cycle();
            ivc_grant[1].sw_grant <= 1'b1;
        end
        next_cycle();
        @(negedge clk);
        assert (!assigned_ovc_not_full[1] && !ovc_available[4])
            else report_error("OVC 4 still shows credit after buf_depth flits");
        for (int c = 0; c < 2; c++) begin
            next_cycle();
            credit_in[4] <= 1'b1;
        end
        for (int c = 0; c < 2; c++) begin
            next_cycle();
            credit_in[4]          <= 1'b1;
            ivc_grant[1].sw_grant <= 1'b1;
        end
        // drain the OVC so a wrong count shows in the flags
        for (int c = 0; c < 2; c++) begin
            next_cycle();
            ivc_grant[1].sw_grant <= 1'b1;
        end
        for (int c = 0; c < 3; c++) begin
            next_cycle();
            credit_in[4] <= 1'b1;
        end
        next_cycle();
        ivc_grant[1].sw_grant <= 1'b1;
        ivc_status[1].tail    <= 1'b1;
        for (int c = 0; c < 2; c++) begin
            next_cycle();
            credit_in[4] <= 1'b1;
        end
        finish_test("OVC credit counting");

        // IVC 14 on port 3, destination index 2 is port 2, VC 1 is OVC 9
        next_cycle();
        ivc_status[14].dst        <= 4'b0100;
        ivc_grant[14].ovc_grant   <= 1'b1;
        ivc_grant[14].granted_ovc <= 4'b0010;
        ovc_allocated[9]          <= 1'b1;
        next_cycle();
        @(negedge clk);
        assert (!ovc_available[9])
            else report_error("OVC 9 is still available after allocation");
        next_cycle();
        ivc_grant[14].sw_grant <= 1'b1;
        ivc_status[14].tail    <= 1'b1;
        next_cycle();
        credit_in[9] <= 1'b1;
        @(negedge clk);
        assert (ovc_available[9] && !ovc_is_assigned[14])
            else report_error("tail through OVC 9 did not free it");
        finish_test("allocation state");

        for (int c = 0; c < 40; c++) begin
            next_cycle();
            for (int i = 0; i < np; i++) begin
                rnd = $random(seed);
                ivc_status[i].request    <= rnd[0];
                ivc_status[i].dst        <= noc_port_pkg::dst_onehot_t'(1 << rnd[2:1]);
                candidate_ovc[i]         <= rnd[7:4];
                ivc_grant[i].ovc_grant   <= (rnd[12:8] == 5'd0);
                ivc_grant[i].granted_ovc <= noc_port_pkg::vc_onehot_t'(1 << rnd[14:13]);
            end
            rnd = $random(seed);
            idx = int'(rnd[9:2]) % np;
            if (rnd[1:0] == 2'd0) begin
                ovc_allocated[idx] <= 1'b1;
            end
        end
        // release every IVC so the sweep below is not masked by assignments
        next_cycle();
        for (int i = 0; i < np; i++) begin
            ivc_grant[i].sw_grant <= 1'b1;
            ivc_status[i].tail    <= 1'b1;
        end
        // every IVC once, each destination index in turn
        for (int i = 0; i < np; i++) begin
            next_cycle();
            ivc_status[i].request <= 1'b1;
            ivc_status[i].dst     <= noc_port_pkg::dst_onehot_t'(1 << (i % 4));
            candidate_ovc[i]      <= '1;
        end
        finish_test("request masking");

        $display("tests run: %0d, errors: %0d", tests_done, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #((run_cycles + margin_cycles) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- tb.f
hdl/noc_port_pkg.sv
hdl/ivc_state.sv
hdl/ovc_status.sv
hdl/vc_request_mask.sv
hdl/inout_ports.sv
sim/tb_inout_ports.sv
